/* design/issue_defs.svh */
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// Physical register number width, 32 registers.
`define ISSUE_PRF_AW 5

// Register and immediate width.
`define ISSUE_DW 16

// Reservation station depth as log2, 4 slots.
`define ISSUE_RS_AW 2

// ROB tag width.
`define ISSUE_ROB_AW 4

`endif

/* design/issue_pkg.sv */
`include "issue_defs.svh"

package issue_pkg;

   typedef logic [`ISSUE_PRF_AW-1:0]      prf_addr_t;   // Physical register number.
   typedef logic [`ISSUE_DW-1:0]          prf_data_t;   // Register value or immediate.
   typedef logic [`ISSUE_ROB_AW-1:0]      rob_id_t;     // ROB tag.
   typedef logic [(1<<`ISSUE_PRF_AW)-1:0] busy_vec_t;   // One bit per physical register.

   typedef enum logic [2:0]
   {
      ADD = 3'd0,
      SUB = 3'd1,
      AND = 3'd2,
      XOR = 3'd3,
      LI  = 3'd4                                        // Result is imm.
   } alu_op_e;

   typedef struct packed
   {
      alu_op_e   op;
      prf_data_t imm;
      prf_addr_t prs1;
      logic      prs1_re;                               // Source 1 is read.
      prf_addr_t prs2;
      logic      prs2_re;                               // Source 2 is read.
      prf_addr_t prd;
      logic      prd_we;                                // Destination is written.
      rob_id_t   rob_id;
   } uop_t;

   typedef struct packed
   {
      logic      valid;
      prf_addr_t prd;
      logic      we;
      prf_data_t data;
      rob_id_t   rob_id;
   } wb_t;

endpackage

/* design/busy_table.sv */
module busy_table
(
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 disp_push,
   input  issue_pkg::uop_t      disp_uop,
   input  issue_pkg::wb_t       wb,
   output issue_pkg::busy_vec_t busy
);
   import issue_pkg::*;

   busy_vec_t set_vec;
   busy_vec_t clr_vec;

   // One-hot set and clear masks for this cycle.
   always_comb
   begin
      set_vec = '0;
      clr_vec = '0;
      if (disp_push && disp_uop.prd_we)
         set_vec[disp_uop.prd] = 1'b1;                  // Result now in flight.
      if (wb.valid && wb.we)
         clr_vec[wb.prd] = 1'b1;                        // Result written back.
   end

   // A dispatch and a writeback to the same register in one cycle would
   // mean the dispatcher reused a destination that is still busy, which
   // the dispatch rules forbid. Should it happen, the set wins and the
   // register stays busy.
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         busy <= '0;
      else
         busy <= (busy & ~clr_vec) | set_vec;
   end

endmodule

/* design/issue_rs.sv */
`include "issue_defs.svh"

module issue_rs
#(
   parameter int RS_AW = `ISSUE_RS_AW
)
(
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 push,
   input  issue_pkg::uop_t      push_uop,
   output logic                 rs_full,
   input  issue_pkg::busy_vec_t busy,
   output logic                 ex_valid,
   input  logic                 ex_pop,
   output issue_pkg::uop_t      ex_uop
);
   import issue_pkg::*;

   localparam int DEPTH = 1 << RS_AW;

   uop_t             slot_q [DEPTH];
   logic [DEPTH-1:0] free_q;
   logic [DEPTH-1:0] free_byp;
   logic [DEPTH-1:0] free_nxt;
   logic [DEPTH-1:0] rdy_vec;
   logic             has_free;
   logic             has_rdy;
   logic             has_rdy_q;
   logic [RS_AW-1:0] free_addr;
   logic [RS_AW-1:0] rdy_addr;
   logic [RS_AW-1:0] rdy_addr_q;

   // Lowest set bit wins.
   function automatic logic [RS_AW-1:0] lowest_set(input logic [DEPTH-1:0] vec);
      logic [RS_AW-1:0] idx;
      idx = '0;
      for (int i = DEPTH - 1; i >= 0; i--)
      begin
         if (vec[i])
            idx = RS_AW'(i);
      end
      return idx;
   endfunction

   assign has_free  = |free_q;
   assign free_addr = lowest_set(free_q);
   assign rs_full   = ~has_free;

   // Slot payload.
   always_ff @(posedge clk)
   begin
      if (push && has_free)
         slot_q[free_addr] <= push_uop;
   end

   // The slot being popped counts as free already, so it is not picked again.
   always_comb
   begin
      free_byp = free_q;
      if (ex_pop)
         free_byp[rdy_addr_q] = 1'b1;
   end

   always_comb
   begin
      free_nxt = free_byp;
      if (push && has_free)
         free_nxt[free_addr] = 1'b0;                    // Claim the slot.
   end

   // Occupied, and every source it reads is no longer in flight.
   always_comb
   begin
      for (int i = 0; i < DEPTH; i++)
      begin
         rdy_vec[i] = ~free_byp[i]
                    & (~slot_q[i].prs1_re | ~busy[slot_q[i].prs1])
                    & (~slot_q[i].prs2_re | ~busy[slot_q[i].prs2]);
      end
   end

   assign has_rdy  = |rdy_vec;
   assign rdy_addr = lowest_set(rdy_vec);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         free_q    <= '1;                               // All slots free.
         has_rdy_q <= 1'b0;
      end
      else
      begin
         free_q    <= free_nxt;
         has_rdy_q <= has_rdy;
      end
   end

   // Selected slot and its micro-op, presented to execute next cycle.
   always_ff @(posedge clk)
   begin
      if (has_rdy)
      begin
         rdy_addr_q <= rdy_addr;
         ex_uop     <= slot_q[rdy_addr];
      end
   end

   assign ex_valid = has_rdy_q;

endmodule

/* design/alu_exec.sv */
`include "issue_defs.svh"

module alu_exec
(
   input  logic            clk,
   input  logic            arst_n,
   input  logic            ex_valid,
   input  issue_pkg::uop_t ex_uop,
   input  logic            hold,
   output logic            ex_pop,
   output issue_pkg::wb_t  wb
);
   import issue_pkg::*;

   localparam int NREG = 1 << `ISSUE_PRF_AW;

   prf_data_t rf_q [NREG];
   prf_data_t rs1_val;
   prf_data_t rs2_val;
   prf_data_t result;

   assign ex_pop = ex_valid & ~hold;                    // Accept unless stalled.

   // Disabled sources read as zero.
   assign rs1_val = ex_uop.prs1_re ? rf_q[ex_uop.prs1] : '0;
   assign rs2_val = ex_uop.prs2_re ? rf_q[ex_uop.prs2] : '0;

   always_comb
   begin
      case (ex_uop.op)
         ADD:     result = rs1_val + rs2_val;           // Wraps.
         SUB:     result = rs1_val - rs2_val;
         AND:     result = rs1_val & rs2_val;
         XOR:     result = rs1_val ^ rs2_val;
         LI:      result = ex_uop.imm;
         default: result = '0;
      endcase
   end

   // Writeback stage, one cycle after the pop.
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         wb <= '0;
      else
      begin
         wb.valid <= ex_pop;
         if (ex_pop)
         begin
            wb.prd    <= ex_uop.prd;
            wb.we     <= ex_uop.prd_we;
            wb.data   <= result;
            wb.rob_id <= ex_uop.rob_id;
         end
      end
   end

   // Register file, written at the end of the writeback cycle.
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < NREG; i++)
            rf_q[i] <= '0;
      end
      else if (wb.valid && wb.we)
         rf_q[wb.prd] <= wb.data;
   end

endmodule

/* design/issue_core.sv */
module issue_core
(
   input  logic            clk,
   input  logic            arst_n,
   input  logic            disp_push,
   input  issue_pkg::uop_t disp_uop,
   input  logic            hold,
   output logic            rs_full,
   output issue_pkg::wb_t  wb
);
   import issue_pkg::*;

   busy_vec_t busy;                                     // Operand readiness.
   logic      ex_valid;
   logic      ex_pop;
   uop_t      ex_uop;

   busy_table u_busy
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .disp_push (disp_push),
      .disp_uop  (disp_uop),
      .wb        (wb),
      .busy      (busy)
   );

   issue_rs u_rs
   (
      .clk      (clk),
      .arst_n   (arst_n),
      .push     (disp_push),
      .push_uop (disp_uop),
      .rs_full  (rs_full),
      .busy     (busy),
      .ex_valid (ex_valid),
      .ex_pop   (ex_pop),
      .ex_uop   (ex_uop)
   );

   alu_exec u_exec
   (
      .clk      (clk),
      .arst_n   (arst_n),
      .ex_valid (ex_valid),
      .ex_uop   (ex_uop),
      .hold     (hold),
      .ex_pop   (ex_pop),
      .wb       (wb)
   );

endmodule

/* bench/issue_tb.sv */
`include "issue_defs.svh"

module issue_tb;
   import issue_pkg::*;

   localparam int NREG   = 1 << `ISSUE_PRF_AW;
   localparam int NROB   = 1 << `ISSUE_ROB_AW;
   localparam int PERIOD = 40;
   localparam int N_OPS  = 111;                         // Micro-ops over all tests.

   logic clk;
   logic arst_n;
   logic disp_push;
   logic hold;
   logic rs_full;
   uop_t disp_uop;
   wb_t  wb;

   prf_data_t   model_rf [NREG];                        // Reference register file.
   logic        pend_dst [NREG];                        // Destination still in flight.
   int          rd_cnt   [NREG];                        // In-flight readers per register.
   uop_t        pend_uop [NROB];
   logic        pending  [NROB];
   logic        retired  [NROB];
   rob_id_t     wb_log   [$];                           // Writeback order.
   rob_id_t     next_rob;
   int          n_pending;
   int          wb_count;
   int unsigned lcg_state;

   issue_core uut
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .disp_push (disp_push),
      .disp_uop  (disp_uop),
      .hold      (hold),
      .rs_full   (rs_full),
      .wb        (wb)
   );

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #(PERIOD * (200 * N_OPS + 1000));
      $display("Timeout: the micro-ops did not all complete in time at %0t", $time);
      stop_fail();
   end

   function automatic int unsigned lcg();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   // Expected ALU result from the reference register file.
   function automatic prf_data_t model_result(input uop_t u);
      prf_data_t a;
      prf_data_t b;
      a = u.prs1_re ? model_rf[u.prs1] : '0;
      b = u.prs2_re ? model_rf[u.prs2] : '0;
      case (u.op)
         ADD:     return a + b;
         SUB:     return a - b;
         AND:     return a & b;
         XOR:     return a ^ b;
         LI:      return u.imm;
         default: return '0;
      endcase
   endfunction

   task automatic stop_fail();
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input prf_data_t exp, input prf_data_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
         stop_fail();
      end
   endtask

   task automatic check_addr(input string name, input prf_addr_t exp, input prf_addr_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
         stop_fail();
      end
   endtask

   task automatic check_rob(input string name, input rob_id_t exp, input rob_id_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
         stop_fail();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
         stop_fail();
      end
   endtask

   task automatic plain_fail(input string what);
      $display("%s at %0t", what, $time);
      stop_fail();
   endtask

   // Checks one writeback and retires it in the model.
   task automatic retire(input wb_t w);
      uop_t u;
      if (!pending[w.rob_id])
      begin
         if (retired[w.rob_id])
            plain_fail($sformatf("Duplicate writeback for rob_id %0d", w.rob_id));
         else
            plain_fail($sformatf("Writeback for unknown rob_id %0d", w.rob_id));
      end
      else
      begin
         u = pend_uop[w.rob_id];
         check_bit("wb.we", u.prd_we, w.we);
         check_addr("wb.prd", u.prd, w.prd);
         check_data("wb.data", model_result(u), w.data);
         if (u.prd_we)
         begin
            model_rf[u.prd] = w.data;
            pend_dst[u.prd] = 1'b0;
         end
         if (u.prs1_re)
            rd_cnt[u.prs1]--;
         if (u.prs2_re)
            rd_cnt[u.prs2]--;
         pending[w.rob_id] = 1'b0;
         retired[w.rob_id] = 1'b1;
         n_pending--;
         wb_count++;
         wb_log.push_back(w.rob_id);
      end
   endtask

   // Sampled just before the edge that ends the writeback cycle.
   always @(posedge clk)
   begin
      if (arst_n && wb.valid)
         retire(wb);
   end

   // Called at a falling edge, returns at a falling edge.
   task automatic dispatch(input alu_op_e op, input prf_data_t imm,
                           input prf_addr_t rs1, input logic re1,
                           input prf_addr_t rs2, input logic re2,
                           input prf_addr_t rd, input logic we, input logic rand_hold);
      uop_t u;
      while (rs_full || pending[next_rob])
      begin
         if (rand_hold)
            hold = (lcg() % 4) == 0;                    // Keep stalls short.
         @(negedge clk);
      end
      u = '{op: op, imm: imm, prs1: rs1, prs1_re: re1, prs2: rs2, prs2_re: re2,
            prd: rd, prd_we: we, rob_id: next_rob};
      pend_uop[next_rob] = u;
      pending[next_rob]  = 1'b1;
      retired[next_rob]  = 1'b0;
      n_pending++;
      if (we)
         pend_dst[rd] = 1'b1;
      if (re1)
         rd_cnt[rs1]++;
      if (re2)
         rd_cnt[rs2]++;
      disp_uop  = u;
      disp_push = 1'b1;
      @(negedge clk);
      disp_push = 1'b0;
      next_rob++;
   endtask

   // A destination that is neither in flight nor read by anything in flight.
   task automatic pick_dst(input prf_addr_t rs1, input logic re1, input prf_addr_t rs2,
                           input logic re2, output prf_addr_t rd);
      int   start;
      int   r;
      logic found;
      start = lcg() % NREG;
      found = 1'b0;
      rd    = '0;
      for (int i = 0; i < NREG; i++)
      begin
         r = (start + i) % NREG;
         if (!found && !pend_dst[r] && rd_cnt[r] == 0 && !(re1 && rs1 == r) &&
             !(re2 && rs2 == r))
         begin
            rd    = prf_addr_t'(r);
            found = 1'b1;
         end
      end
      if (!found)
         plain_fail("No free destination register");
   endtask

   task automatic wait_idle();
      while (n_pending != 0)
         @(negedge clk);
   endtask

   task automatic reset_values();
      check_bit("rs_full", 1'b0, rs_full);
      check_bit("wb.valid", 1'b0, wb.valid);
      dispatch(ADD, '0, 5'd11, 1'b1, 5'd12, 1'b1, 5'd10, 1'b1, 1'b0);
      wait_idle();
   endtask

   task automatic independent_ops();
      for (int i = 1; i <= 4; i++)
         dispatch(LI, prf_data_t'(lcg()), '0, 1'b0, '0, 1'b0, prf_addr_t'(i), 1'b1, 1'b0);
      dispatch(ADD, '0, 5'd1, 1'b1, 5'd2, 1'b1, 5'd5, 1'b1, 1'b0);
      dispatch(SUB, '0, 5'd1, 1'b1, 5'd3, 1'b1, 5'd6, 1'b1, 1'b0);
      dispatch(AND, '0, 5'd2, 1'b1, 5'd4, 1'b1, 5'd7, 1'b1, 1'b0);
      dispatch(XOR, '0, 5'd3, 1'b1, 5'd4, 1'b1, 5'd8, 1'b1, 1'b0);
      wait_idle();
   endtask

   task automatic dependency_chain();
      rob_id_t   order [$];
      prf_addr_t prev;
      prf_addr_t prev2;
      wb_log.delete();
      order.push_back(next_rob);
      dispatch(LI, prf_data_t'(lcg()), '0, 1'b0, '0, 1'b0, 5'd20, 1'b1, 1'b0);
      prev  = 5'd20;
      prev2 = 5'd20;
      for (int i = 0; i < 5; i++)
      begin
         order.push_back(next_rob);
         dispatch(ADD, '0, prev, 1'b1, prev2, 1'b1, prf_addr_t'(21 + i), 1'b1, 1'b0);
         prev2 = prev;
         prev  = prf_addr_t'(21 + i);
      end
      wait_idle();
      if (wb_log.size() != order.size())
         plain_fail("Chain writeback count is wrong");
      foreach (order[i])
         check_rob("wb.rob_id", order[i], wb_log[i]);
   endtask

   task automatic backpressure_full();
      int base;
      base = wb_count;
      hold = 1'b1;
      for (int i = 0; i < 4; i++)
         dispatch(LI, prf_data_t'(lcg()), '0, 1'b0, '0, 1'b0, prf_addr_t'(26 + i), 1'b1, 1'b0);
      check_bit("rs_full", 1'b1, rs_full);
      repeat (8) @(negedge clk);
      if (wb_count != base)
         plain_fail("Writeback appeared while hold was high");
      hold = 1'b0;
      wait_idle();
      if (wb_count != base + 4)
         plain_fail("Not all held micro-ops completed");
      check_bit("rs_full", 1'b0, rs_full);
   endtask

   task automatic random_stream();
      alu_op_e   op;
      prf_addr_t rs1;
      prf_addr_t rs2;
      prf_addr_t rd;
      logic      re1;
      logic      re2;
      for (int n = 0; n < 60; n++)
      begin
         op  = alu_op_e'(lcg() % 5);
         rs1 = prf_addr_t'(lcg());
         rs2 = prf_addr_t'(lcg());
         re1 = (lcg() % 8) != 0;
         re2 = (lcg() % 8) != 0;
         pick_dst(rs1, re1, rs2, re2, rd);
         hold = (lcg() % 4) == 0;
         dispatch(op, prf_data_t'(lcg()), rs1, re1, rs2, re2, rd, 1'b1, 1'b1);
      end
      hold = 1'b0;
      wait_idle();
      // Read every register back through the ALU without writing it.
      for (int r = 0; r < NREG; r++)
         dispatch(ADD, '0, prf_addr_t'(r), 1'b1, '0, 1'b0, '0, 1'b0, 1'b0);
      wait_idle();
   endtask

   initial
   begin
      arst_n    = 1'b0;
      disp_push = 1'b0;
      disp_uop  = '0;
      hold      = 1'b0;
      lcg_state = 54;
      next_rob  = '0;
      n_pending = 0;
      wb_count  = 0;
      for (int i = 0; i < NREG; i++)
      begin
         model_rf[i] = '0;
         pend_dst[i] = 1'b0;
         rd_cnt[i]   = 0;
      end
      for (int i = 0; i < NROB; i++)
      begin
         pending[i] = 1'b0;
         retired[i] = 1'b0;
      end
      repeat (5) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      reset_values();
      independent_ops();
      dependency_chain();
      backpressure_full();
      random_stream();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

/* src.f */
+incdir+design
design/issue_pkg.sv
design/busy_table.sv
design/issue_rs.sv
design/alu_exec.sv
design/issue_core.sv
bench/issue_tb.sv

/* Bender.yml */
package:
  name: issue_core

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/issue_pkg.sv
      - design/busy_table.sv
      - design/issue_rs.sv
      - design/alu_exec.sv
      - design/issue_core.sv
      - target: test
        files:
          - bench/issue_tb.sv
